// ==== list.f ====
src/gnss_signal_pkg.sv
src/track_pkg.sv
src/corr_if.sv
src/ca_code_gen.sv
src/carrier_nco.sv
src/subchannel.sv
src/power_calc.sv
src/tracking_channel.sv
bench/tb_tracking_channel.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_tracking_channel -f list.f \
   || { echo "build failed"; exit 1; }
./obj_dir/Vtb_tracking_channel | tee /dev/stderr | grep "^NO ERRORS$" > /dev/null \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// ==== bench/tb_tracking_channel.sv ====
`timescale 1ns/1ps

module tb_tracking_channel import gnss_signal_pkg::*, track_pkg::*; ();

   localparam int ACC_WIDTH     = 16;
   localparam int MULT_STAGES   = 4;
   localparam int SEEK_TIMEOUT  = 2 * CODE_LEN;
   localparam int POWER_TIMEOUT = 1 + 3 * (MULT_STAGES + 2) + 20;
   localparam int ARM_OFFSET [NUM_ARMS] = '{1, 0, -1};

   logic                           clk;
   logic                           i_rst;
   logic                           i_data_available;
   logic                           i_feed_complete;
   logic signed [SAMPLE_WIDTH-1:0] i_data;
   logic signed [PHASE_WIDTH-1:0]  i_doppler_early;
   logic signed [PHASE_WIDTH-1:0]  i_doppler_prompt;
   logic signed [PHASE_WIDTH-1:0]  i_doppler_late;
   logic [4:0]                     i_prn;
   logic                           i_seek_en;
   logic [CHIP_WIDTH-1:0]          i_seek_target;
   logic [CHIP_WIDTH-1:0]          o_code_shift;
   logic                           o_seek_busy;
   logic signed [ACC_WIDTH-1:0]    o_accumulator_i;
   logic signed [ACC_WIDTH-1:0]    o_accumulator_q;
   logic                           o_i2q2_valid;
   logic [2*ACC_WIDTH:0]           o_i2q2_early;
   logic [2*ACC_WIDTH:0]           o_i2q2_prompt;
   logic [2*ACC_WIDTH:0]           o_i2q2_late;
   logic                           o_ca_bit;
   logic                           o_ca_clk;

   // Signal model state.
   logic                   code_tab [CODE_LEN];
   int                     model_idx [NUM_ARMS];
   logic [PHASE_WIDTH-1:0] model_phase [NUM_ARMS];
   logic [PHASE_WIDTH-1:0] model_dop [NUM_ARMS];
   int                     model_acc_i [NUM_ARMS];
   int                     model_acc_q [NUM_ARMS];
   logic                   ca_expect [$];
   int                     errors;

   tracking_channel i_dut (.*);

   initial begin
      clk = 1'b0;
      forever begin
         #5 clk = ~clk;
      end
   end

   task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                              input string what);
      if (got !== exp) begin
         errors++;
         $display("error at %0t ns: %s is %0d, expected %0d", $time, what,
                  $signed(got), $signed(exp));
         $display("ERRORS FOUND");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic fail_now(input string reason);
      errors++;
      $display("%s at %0t ns", reason, $time);
      $display("ERRORS FOUND");
      $fatal(1, "run aborted");
   endtask

   // Standard C/A generator, G1 taps 3 and 10, G2 taps 2 3 6 8 9 10.
   task automatic build_code(input logic [4:0] prn);
      logic [10:1] g1;
      logic [10:1] g2;
      logic [3:0]  tap_a;
      logic [3:0]  tap_b;
      g1    = '1;
      g2    = '1;
      tap_a = prn_taps[prn][0];
      tap_b = prn_taps[prn][1];
      for (int n = 0; n < CODE_LEN; n++) begin
         code_tab[n] = g1[10] ^ g2[tap_a] ^ g2[tap_b];
         g1 = {g1[9:1], g1[3] ^ g1[10]};
         g2 = {g2[9:1], g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10]};
      end
   endtask

   function automatic int mix_term(input int sample, input logic chip, input int trig);
      int prod;
      prod = sample * trig;
      return chip ? -prod : prod;
   endfunction

   function automatic longint expected_power(input int acc_i, input int acc_q);
      longint mag_i;
      longint mag_q;
      mag_i = (acc_i < 0) ? -acc_i : acc_i;
      mag_q = (acc_q < 0) ? -acc_q : acc_q;
      return mag_i * mag_i + mag_q * mag_q;
   endfunction

   // Mixes one sample into all three arms, then steps code and carrier.
   function automatic void correlate_sample(input int sample);
      logic                   chip;
      logic [SECTOR_BITS-1:0] sector;
      for (int a = 0; a < NUM_ARMS; a++) begin
         chip   = code_tab[model_idx[a]];
         sector = model_phase[a][PHASE_WIDTH-1 -: SECTOR_BITS];
         model_acc_i[a] += mix_term(sample, chip, cos_table[sector]);
         model_acc_q[a] += mix_term(sample, chip, sin_table[sector]);
         model_phase[a] = model_phase[a] + model_dop[a];
         model_idx[a]   = (model_idx[a] + 1) % CODE_LEN;
      end
      ca_expect.push_back(code_tab[model_idx[ARM_PROMPT]]);
   endfunction

   task automatic check_reset_state();
      check_equal(o_i2q2_valid, 0, "o_i2q2_valid after reset");
      check_equal(o_seek_busy, 0, "o_seek_busy after reset");
      check_equal(o_ca_clk, 0, "o_ca_clk after reset");
      check_equal(o_code_shift, 0, "o_code_shift after reset");
      check_equal(o_accumulator_i, 0, "o_accumulator_i after reset");
      check_equal(o_accumulator_q, 0, "o_accumulator_q after reset");
      check_equal(o_i2q2_early, 0, "o_i2q2_early after reset");
      check_equal(o_i2q2_prompt, 0, "o_i2q2_prompt after reset");
      check_equal(o_i2q2_late, 0, "o_i2q2_late after reset");
   endtask

   task automatic seek_to(input int target);
      int waited;
      waited        = 0;
      i_seek_target = CHIP_WIDTH'(target);
      i_seek_en     = 1'b1;
      @(posedge clk);
      #1;
      i_seek_en = 1'b0;
      while (o_seek_busy !== 1'b0) begin
         if (waited == SEEK_TIMEOUT) begin
            fail_now("timeout waiting for o_seek_busy to fall");
         end
         waited++;
         @(posedge clk);
         #1;
      end
      check_equal(o_code_shift, target, "o_code_shift after seek");
      for (int a = 0; a < NUM_ARMS; a++) begin
         model_idx[a] = (target + ARM_OFFSET[a] + CODE_LEN) % CODE_LEN;
      end
   endtask

   // Random samples with idle gaps; the last one closes the feed.
   task automatic run_feed(input int n);
      int                             gap;
      logic signed [SAMPLE_WIDTH-1:0] sample;
      for (int a = 0; a < NUM_ARMS; a++) begin
         model_dop[a] = PHASE_WIDTH'($urandom);
      end
      i_doppler_early  = model_dop[ARM_EARLY];
      i_doppler_prompt = model_dop[ARM_PROMPT];
      i_doppler_late   = model_dop[ARM_LATE];
      for (int k = 0; k < n; k++) begin
         gap = $urandom_range(3, 0);
         repeat (gap) begin
            @(posedge clk);
            #1;
         end
         sample           = SAMPLE_WIDTH'($urandom);
         i_data           = sample;
         i_data_available = 1'b1;
         i_feed_complete  = (k == n - 1);
         correlate_sample(sample);
         @(posedge clk);
         #1;
         i_data_available = 1'b0;
         i_feed_complete  = 1'b0;
      end
      // Last sample has passed mix and accumulate.
      @(posedge clk);
      #1;
      check_equal(o_accumulator_i, model_acc_i[ARM_PROMPT], "o_accumulator_i at feed end");
      check_equal(o_accumulator_q, model_acc_q[ARM_PROMPT], "o_accumulator_q at feed end");
   endtask

   task automatic check_powers();
      int     waited;
      longint exp_pow [NUM_ARMS];
      for (int a = 0; a < NUM_ARMS; a++) begin
         exp_pow[a] = expected_power(model_acc_i[a], model_acc_q[a]);
      end
      waited = 0;
      while (o_i2q2_valid !== 1'b1) begin
         if (waited == POWER_TIMEOUT) begin
            fail_now("timeout waiting for o_i2q2_valid");
         end
         waited++;
         @(posedge clk);
         #1;
      end
      check_equal(o_i2q2_early, exp_pow[ARM_EARLY], "o_i2q2_early");
      check_equal(o_i2q2_prompt, exp_pow[ARM_PROMPT], "o_i2q2_prompt");
      check_equal(o_i2q2_late, exp_pow[ARM_LATE], "o_i2q2_late");
      check_equal(o_accumulator_i, 0, "o_accumulator_i after dump");
      check_equal(o_accumulator_q, 0, "o_accumulator_q after dump");
      check_equal(ca_expect.size(), 0, "code chips still pending");
      for (int a = 0; a < NUM_ARMS; a++) begin
         model_acc_i[a] = 0;
         model_acc_q[a] = 0;
      end
   endtask

   // Seek slewing also pulses o_ca_clk, but only while busy.
   always @(negedge clk) begin
      if (o_ca_clk === 1'b1 && o_seek_busy === 1'b0) begin
         if (ca_expect.size() == 0) begin
            fail_now("o_ca_clk pulsed with no accepted sample pending");
         end else begin
            check_equal(o_ca_bit, ca_expect.pop_front(), "o_ca_bit");
         end
      end
   end

   initial begin
      logic [4:0] prn;
      void'($urandom(32'h92f29299));
      errors           = 0;
      i_rst            = 1'b1;
      i_data_available = 1'b0;
      i_feed_complete  = 1'b0;
      i_data           = '0;
      i_doppler_early  = '0;
      i_doppler_prompt = '0;
      i_doppler_late   = '0;
      i_prn            = '0;
      i_seek_en        = 1'b0;
      i_seek_target    = '0;
      for (int a = 0; a < NUM_ARMS; a++) begin
         model_idx[a]   = 0;
         model_phase[a] = '0;
         model_dop[a]   = '0;
         model_acc_i[a] = 0;
         model_acc_q[a] = 0;
      end
      repeat (10) @(posedge clk);
      #1;
      i_rst = 1'b0;
      check_reset_state();

      prn   = 5'($urandom);
      i_prn = prn;
      build_code(prn);

      // Longer than one epoch so the index wraps.
      run_feed(CODE_LEN + 8 + $urandom_range(40, 0));
      check_powers();

      seek_to($urandom_range(CODE_LEN - 1, 0));
      run_feed($urandom_range(200, 50));
      check_powers();

      seek_to($urandom_range(CODE_LEN - 1, 0));
      run_feed($urandom_range(200, 50));
      check_powers();
      run_feed($urandom_range(200, 50));
      check_powers();

      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// ==== src/tracking_channel.sv ====
`timescale 1ns/1ps

module tracking_channel import gnss_signal_pkg::*, track_pkg::*; #(
   parameter int ACC_WIDTH   = 16,
   parameter int MULT_STAGES = 4
) (
   input  logic                           clk,
   input  logic                           i_rst,
   input  logic                           i_data_available,
   input  logic                           i_feed_complete,
   input  logic signed [SAMPLE_WIDTH-1:0] i_data,
   input  logic signed [PHASE_WIDTH-1:0]  i_doppler_early,
   input  logic signed [PHASE_WIDTH-1:0]  i_doppler_prompt,
   input  logic signed [PHASE_WIDTH-1:0]  i_doppler_late,
   input  logic [4:0]                     i_prn,
   input  logic                           i_seek_en,
   input  logic [CHIP_WIDTH-1:0]          i_seek_target,
   output logic [CHIP_WIDTH-1:0]          o_code_shift,
   output logic                           o_seek_busy,
   output logic signed [ACC_WIDTH-1:0]    o_accumulator_i,
   output logic signed [ACC_WIDTH-1:0]    o_accumulator_q,
   output logic                           o_i2q2_valid,
   output logic [2*ACC_WIDTH:0]           o_i2q2_early,
   output logic [2*ACC_WIDTH:0]           o_i2q2_prompt,
   output logic [2*ACC_WIDTH:0]           o_i2q2_late,
   output logic                           o_ca_bit,
   output logic                           o_ca_clk
);

   localparam int EARLY_IDX  = int'(ARM_EARLY);
   localparam int PROMPT_IDX = int'(ARM_PROMPT);
   localparam int LATE_IDX   = int'(ARM_LATE);

   logic signed [PHASE_WIDTH-1:0] doppler [NUM_ARMS];
   logic [NUM_ARMS-1:0]           seeking;
   logic                          sample_strobe;
   logic                          feed_d1;
   logic                          dump;

   corr_if #(.ACC_WIDTH(ACC_WIDTH)) corr [NUM_ARMS] ();

   assign doppler[EARLY_IDX]  = i_doppler_early;
   assign doppler[PROMPT_IDX] = i_doppler_prompt;
   assign doppler[LATE_IDX]   = i_doppler_late;

   assign o_seek_busy   = |seeking;
   assign sample_strobe = i_data_available && !o_seek_busy;

   // Early leads by one chip, late trails by one.
   for (genvar k = 0; k < NUM_ARMS; k++) begin : g_arm
      subchannel #(
         .ACC_WIDTH   (ACC_WIDTH),
         .CODE_OFFSET (1 - k)
      ) u_sub (
         .clk              (clk),
         .i_rst            (i_rst),
         .i_data_available (sample_strobe),
         .i_data           (i_data),
         .i_doppler        (doppler[k]),
         .i_prn            (i_prn),
         .i_seek_en        (i_seek_en),
         .i_seek_target    (i_seek_target),
         .i_dump           (dump),
         .o_corr           (corr[k])
      );
      assign seeking[k] = corr[k].seeking;
   end

   // Two stages so the last sample reaches the accumulators.
   always_ff @(posedge clk) begin
      if (i_rst) begin
         feed_d1 <= 1'b0;
         dump    <= 1'b0;
      end else begin
         feed_d1 <= i_feed_complete;
         dump    <= feed_d1;
      end
   end

   power_calc #(
      .ACC_WIDTH   (ACC_WIDTH),
      .MULT_STAGES (MULT_STAGES)
   ) u_power (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_dump        (dump),
      .i_corr        (corr),
      .o_i2q2_valid  (o_i2q2_valid),
      .o_i2q2_early  (o_i2q2_early),
      .o_i2q2_prompt (o_i2q2_prompt),
      .o_i2q2_late   (o_i2q2_late)
   );

   assign o_code_shift    = corr[PROMPT_IDX].code_shift;
   assign o_accumulator_i = corr[PROMPT_IDX].acc_i;
   assign o_accumulator_q = corr[PROMPT_IDX].acc_q;
   assign o_ca_bit        = corr[PROMPT_IDX].ca_bit;
   assign o_ca_clk        = corr[PROMPT_IDX].ca_clk;

   a_no_dump_while_seeking: assert property (
      @(posedge clk) disable iff (i_rst) dump |-> !o_seek_busy
   ) else $error("dump while a subchannel is seeking");

endmodule

// ==== src/power_calc.sv ====
`timescale 1ns/1ps

module power_calc import track_pkg::*; #(
   parameter int ACC_WIDTH   = 16,
   parameter int MULT_STAGES = 4
) (
   input  logic               clk,
   input  logic               i_rst,
   input  logic               i_dump,
   corr_if.dst                i_corr [NUM_ARMS],
   output logic               o_i2q2_valid,
   output logic [2*ACC_WIDTH:0] o_i2q2_early,
   output logic [2*ACC_WIDTH:0] o_i2q2_prompt,
   output logic [2*ACC_WIDTH:0] o_i2q2_late
);

   localparam int PASS_LEN  = MULT_STAGES + 2;
   localparam int CNT_WIDTH = $clog2(PASS_LEN);
   localparam int SQ_WIDTH  = 2 * ACC_WIDTH;

   logic [ACC_WIDTH-1:0] abs_i [NUM_ARMS];
   logic [ACC_WIDTH-1:0] abs_q [NUM_ARMS];
   logic [ACC_WIDTH-1:0] mag_i [NUM_ARMS];
   logic [ACC_WIDTH-1:0] mag_q [NUM_ARMS];
   logic [ACC_WIDTH-1:0] sq_in [2];
   logic [SQ_WIDTH-1:0]  sq_pipe [2][MULT_STAGES];
   logic [SQ_WIDTH:0]    sum_q;
   arm_e                 sel;
   logic                 active;
   logic [CNT_WIDTH-1:0] cnt;
   logic                 pass_done;

   function automatic logic [ACC_WIDTH-1:0] magnitude(input logic signed [ACC_WIDTH-1:0] v);
      return v[ACC_WIDTH-1] ? ACC_WIDTH'(-v) : ACC_WIDTH'(v);
   endfunction

   for (genvar k = 0; k < NUM_ARMS; k++) begin : g_abs
      assign abs_i[k] = magnitude(i_corr[k].acc_i);
      assign abs_q[k] = magnitude(i_corr[k].acc_q);
   end

   always_ff @(posedge clk) begin
      if (i_dump) begin
         mag_i <= abs_i;
         mag_q <= abs_q;
      end
   end

   // Lane 0 squares I, lane 1 squares Q.
   assign sq_in[0] = mag_i[sel];
   assign sq_in[1] = mag_q[sel];

   // Trailing stages let the multiplier retime.
   always_ff @(posedge clk) begin
      for (int l = 0; l < 2; l++) begin
         sq_pipe[l][0] <= SQ_WIDTH'(sq_in[l]) * SQ_WIDTH'(sq_in[l]);
         for (int s = 1; s < MULT_STAGES; s++) begin
            sq_pipe[l][s] <= sq_pipe[l][s-1];
         end
      end
      sum_q <= {1'b0, sq_pipe[0][MULT_STAGES-1]} + {1'b0, sq_pipe[1][MULT_STAGES-1]};
   end

   assign pass_done = active && (cnt == CNT_WIDTH'(PASS_LEN - 1));

   // One pass per arm, early first.
   always_ff @(posedge clk) begin
      if (i_rst) begin
         active <= 1'b0;
         sel    <= ARM_EARLY;
         cnt    <= '0;
      end else if (i_dump) begin
         active <= 1'b1;
         sel    <= ARM_EARLY;
         cnt    <= '0;
      end else if (active) begin
         if (pass_done) begin
            cnt <= '0;
            sel <= next_arm(sel);
            if (sel == ARM_LATE) begin
               active <= 1'b0;
            end
         end else begin
            cnt <= cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_i2q2_valid  <= 1'b0;
         o_i2q2_early  <= '0;
         o_i2q2_prompt <= '0;
         o_i2q2_late   <= '0;
      end else begin
         o_i2q2_valid <= pass_done && (sel == ARM_LATE);
         if (pass_done) begin
            case (sel)
               ARM_EARLY:  o_i2q2_early  <= sum_q;
               ARM_PROMPT: o_i2q2_prompt <= sum_q;
               default:    o_i2q2_late   <= sum_q;
            endcase
         end
      end
   end

   a_sel_range: assert property (
      @(posedge clk) disable iff (i_rst) sel inside {ARM_EARLY, ARM_PROMPT, ARM_LATE}
   ) else $error("power select outside the arm range");

endmodule

// ==== src/subchannel.sv ====
`timescale 1ns/1ps

module subchannel import gnss_signal_pkg::*; #(
   parameter int ACC_WIDTH   = 16,
   parameter int CODE_OFFSET = 0
) (
   input  logic                           clk,
   input  logic                           i_rst,
   input  logic                           i_data_available,
   input  logic signed [SAMPLE_WIDTH-1:0] i_data,
   input  logic signed [PHASE_WIDTH-1:0]  i_doppler,
   input  logic [4:0]                     i_prn,
   input  logic                           i_seek_en,
   input  logic [CHIP_WIDTH-1:0]          i_seek_target,
   input  logic                           i_dump,
   corr_if.src                            o_corr
);

   // Offset folded into 0..CODE_LEN-1.
   localparam int OFFSET_MOD = ((CODE_OFFSET % CODE_LEN) + CODE_LEN) % CODE_LEN;

   logic [CHIP_WIDTH:0]            target_sum;
   logic [CHIP_WIDTH-1:0]          target;
   logic                           accept;
   logic                           chip;
   logic [CHIP_WIDTH-1:0]          chip_idx;
   logic                           seeking;
   logic                           ca_clk;
   logic signed [TRIG_WIDTH-1:0]   cos_val;
   logic signed [TRIG_WIDTH-1:0]   sin_val;
   logic signed [MIX_WIDTH-1:0]    prod_i;
   logic signed [MIX_WIDTH-1:0]    prod_q;
   logic signed [MIX_WIDTH-1:0]    mix_i;
   logic signed [MIX_WIDTH-1:0]    mix_q;
   logic                           mix_valid;
   logic signed [ACC_WIDTH-1:0]    acc_i;
   logic signed [ACC_WIDTH-1:0]    acc_q;

   assign target_sum = {1'b0, i_seek_target} + (CHIP_WIDTH + 1)'(OFFSET_MOD);
   assign target     = (target_sum >= CODE_LEN) ? CHIP_WIDTH'(target_sum - CODE_LEN)
                                                : CHIP_WIDTH'(target_sum);

   assign accept = i_data_available && !seeking;

   ca_code_gen u_code (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_prn         (i_prn),
      .i_advance     (accept),
      .i_seek_en     (i_seek_en),
      .i_seek_target (target),
      .o_chip        (chip),
      .o_chip_idx    (chip_idx),
      .o_seeking     (seeking),
      .o_ca_clk      (ca_clk)
   );

   carrier_nco u_nco (
      .clk       (clk),
      .i_rst     (i_rst),
      .i_step    (accept),
      .i_doppler (i_doppler),
      .o_cos     (cos_val),
      .o_sin     (sin_val)
   );

   assign prod_i = MIX_WIDTH'(i_data) * MIX_WIDTH'(cos_val);
   assign prod_q = MIX_WIDTH'(i_data) * MIX_WIDTH'(sin_val);

   // Chip value 1 wipes off as -1.
   always_ff @(posedge clk) begin
      if (accept) begin
         mix_i <= chip ? -prod_i : prod_i;
         mix_q <= chip ? -prod_q : prod_q;
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         mix_valid <= 1'b0;
         acc_i     <= '0;
         acc_q     <= '0;
      end else begin
         mix_valid <= accept;
         if (i_dump) begin
            acc_i <= '0;
            acc_q <= '0;
         end else if (mix_valid) begin
            acc_i <= acc_i + ACC_WIDTH'(mix_i);
            acc_q <= acc_q + ACC_WIDTH'(mix_q);
         end
      end
   end

   assign o_corr.code_shift = chip_idx;
   assign o_corr.seeking    = seeking;
   assign o_corr.acc_i      = acc_i;
   assign o_corr.acc_q      = acc_q;
   assign o_corr.ca_bit     = chip;
   assign o_corr.ca_clk     = ca_clk;

endmodule

// ==== src/carrier_nco.sv ====
`timescale 1ns/1ps

module carrier_nco import gnss_signal_pkg::*; (
   input  logic                          clk,
   input  logic                          i_rst,
   input  logic                          i_step,
   input  logic signed [PHASE_WIDTH-1:0] i_doppler,
   output logic signed [TRIG_WIDTH-1:0]  o_cos,
   output logic signed [TRIG_WIDTH-1:0]  o_sin
);

   logic [PHASE_WIDTH-1:0] phase;
   logic [SECTOR_BITS-1:0] sector;

   // Top phase bits pick the 45 degree sector.
   assign sector = phase[PHASE_WIDTH-1 -: SECTOR_BITS];

   assign o_cos = cos_table[sector];
   assign o_sin = sin_table[sector];

   // Negative Doppler wraps the phase backwards.
   always_ff @(posedge clk) begin
      if (i_rst) begin
         phase <= '0;
      end else if (i_step) begin
         phase <= phase + $unsigned(i_doppler);
      end
   end

endmodule

// ==== src/ca_code_gen.sv ====
`timescale 1ns/1ps

module ca_code_gen import gnss_signal_pkg::*; (
   input  logic                  clk,
   input  logic                  i_rst,
   input  logic [4:0]            i_prn,
   input  logic                  i_advance,
   input  logic                  i_seek_en,
   input  logic [CHIP_WIDTH-1:0] i_seek_target,
   output logic                  o_chip,
   output logic [CHIP_WIDTH-1:0] o_chip_idx,
   output logic                  o_seeking,
   output logic                  o_ca_clk
);

   logic [10:1]           g1;
   logic [10:1]           g2;
   logic [3:0]            tap_a;
   logic [3:0]            tap_b;
   logic [CHIP_WIDTH-1:0] target;
   logic                  step;
   logic                  epoch_end;

   assign tap_a = prn_taps[i_prn][0];
   assign tap_b = prn_taps[i_prn][1];

   // G2 phase selection by the PRN tap pair.
   assign o_chip = g1[10] ^ g2[tap_a] ^ g2[tap_b];

   // Slew one chip per clock until on target.
   assign step = o_seeking ? (o_chip_idx != target) : i_advance;

   assign epoch_end = (o_chip_idx == CHIP_WIDTH'(CODE_LEN - 1));

   always_ff @(posedge clk) begin
      if (i_rst) begin
         g1         <= '1;
         g2         <= '1;
         o_chip_idx <= '0;
         o_seeking  <= 1'b0;
         o_ca_clk   <= 1'b0;
      end else begin
         o_ca_clk <= step;
         if (step) begin
            if (epoch_end) begin
               g1         <= '1;
               g2         <= '1;
               o_chip_idx <= '0;
            end else begin
               g1         <= {g1[9:1], g1[3] ^ g1[10]};
               g2         <= {g2[9:1], g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10]};
               o_chip_idx <= o_chip_idx + 1'b1;
            end
         end
         if (i_seek_en) begin
            o_seeking <= 1'b1;
         end else if (o_seeking && o_chip_idx == target) begin
            o_seeking <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_seek_en) begin
         target <= i_seek_target;
      end
   end

   a_chip_idx_range: assert property (
      @(posedge clk) disable iff (i_rst) o_chip_idx < CHIP_WIDTH'(CODE_LEN)
   ) else $error("chip index outside the code epoch");

endmodule

// ==== src/corr_if.sv ====
`timescale 1ns/1ps

interface corr_if import gnss_signal_pkg::*; #(
   parameter int ACC_WIDTH = 16
) ();

   logic [CHIP_WIDTH-1:0]       code_shift;
   logic                        seeking;
   logic signed [ACC_WIDTH-1:0] acc_i;
   logic signed [ACC_WIDTH-1:0] acc_q;
   logic                        ca_bit;
   logic                        ca_clk;

   modport src (
      output code_shift,
      output seeking,
      output acc_i,
      output acc_q,
      output ca_bit,
      output ca_clk
   );

   modport dst (
      input code_shift,
      input seeking,
      input acc_i,
      input acc_q,
      input ca_bit,
      input ca_clk
   );

endinterface

// ==== src/track_pkg.sv ====
package track_pkg;

   // Correlator arms in power sequencing order.
   typedef enum logic [1:0] {
      ARM_EARLY  = 2'd0,
      ARM_PROMPT = 2'd1,
      ARM_LATE   = 2'd2
   } arm_e;

   localparam int NUM_ARMS = 3;

   // Arm squared after the given one.
   function automatic arm_e next_arm(input arm_e arm);
      case (arm)
         ARM_EARLY:  return ARM_PROMPT;
         ARM_PROMPT: return ARM_LATE;
         default:    return ARM_EARLY;
      endcase
   endfunction

endpackage

// ==== src/gnss_signal_pkg.sv ====
package gnss_signal_pkg;

   // Sample and correlator formats.
   localparam int SAMPLE_WIDTH = 3;
   localparam int TRIG_WIDTH   = 3;
   localparam int MIX_WIDTH    = SAMPLE_WIDTH + TRIG_WIDTH;

   // Carrier phase and Doppler word.
   localparam int PHASE_WIDTH = 16;
   localparam int SECTOR_BITS = 3;

   // C/A code epoch.
   localparam int CODE_LEN   = 1023;
   localparam int CHIP_WIDTH = 10;

   // G2 tap pairs, entry 0 is PRN 1.
   localparam logic [3:0] prn_taps [32][2] = '{
      '{4'd2, 4'd6}, '{4'd3, 4'd7}, '{4'd4, 4'd8}, '{4'd5, 4'd9},
      '{4'd1, 4'd9}, '{4'd2, 4'd10}, '{4'd1, 4'd8}, '{4'd2, 4'd9},
      '{4'd3, 4'd10}, '{4'd2, 4'd3}, '{4'd3, 4'd4}, '{4'd5, 4'd6},
      '{4'd6, 4'd7}, '{4'd7, 4'd8}, '{4'd8, 4'd9}, '{4'd9, 4'd10},
      '{4'd1, 4'd4}, '{4'd2, 4'd5}, '{4'd3, 4'd6}, '{4'd4, 4'd7},
      '{4'd5, 4'd8}, '{4'd6, 4'd9}, '{4'd1, 4'd3}, '{4'd4, 4'd6},
      '{4'd5, 4'd7}, '{4'd6, 4'd8}, '{4'd7, 4'd9}, '{4'd8, 4'd10},
      '{4'd1, 4'd6}, '{4'd2, 4'd7}, '{4'd3, 4'd8}, '{4'd4, 4'd9}
   };

   // Two-bit carrier replica, one value per 45 degree sector.
   localparam logic signed [TRIG_WIDTH-1:0] cos_table [2**SECTOR_BITS] = '{
      3'sd2, 3'sd1, -3'sd1, -3'sd2,
      -3'sd2, -3'sd1, 3'sd1, 3'sd2
   };

   localparam logic signed [TRIG_WIDTH-1:0] sin_table [2**SECTOR_BITS] = '{
      3'sd1, 3'sd2, 3'sd2, 3'sd1,
      -3'sd1, -3'sd2, -3'sd2, -3'sd1
   };

endpackage
